/* ce_pkg.sv */
// Shared definitions for the copy engine. Beat counts are 16 bits, so a transfer holds at most 65535 beats
package ce_pkg;

   // Register port widths
   localparam int CSR_ADDR_W = 4;
   localparam int CSR_DATA_W = 32;

   // Beat count, one 16-bit word
   typedef logic [15:0] beat_cnt_t;

   // --------------------
   // Register map
   localparam logic [CSR_ADDR_W-1:0] REG_SRC_ADDR   = 4'd0;
   localparam logic [CSR_ADDR_W-1:0] REG_DST_ADDR   = 4'd1;
   localparam logic [CSR_ADDR_W-1:0] REG_SIZE       = 4'd2;
   localparam logic [CSR_ADDR_W-1:0] REG_CTRL       = 4'd3;
   localparam logic [CSR_ADDR_W-1:0] REG_STATUS     = 4'd4;
   localparam logic [CSR_ADDR_W-1:0] REG_BEATS_DONE = 4'd5;

   // Status word bit positions
   localparam int STAT_BUSY = 0;
   localparam int STAT_DONE = 1;
   localparam int STAT_ERR  = 2;

   // --------------------
   // Transfer states
   typedef enum logic [2:0] {
      IDLE  = 3'd0,
      REQ   = 3'd1,
      DRAIN = 3'd2,
      DONE  = 3'd3,
      ERR   = 3'd4
   } ce_state_e;

endpackage

/* ce_csr.sv */
`timescale 1ns/1ns
// ADDR_W must not exceed the 32-bit register word and only the low 16 bits of a size write are kept
module ce_csr #(
   parameter int ADDR_W = 32
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            csr_wr,
   input  logic                            csr_rd,
   input  logic [ce_pkg::CSR_ADDR_W-1:0]   csr_addr,
   input  logic [ce_pkg::CSR_DATA_W-1:0]   csr_wdata,
   output logic [ce_pkg::CSR_DATA_W-1:0]   csr_rdata,
   input  logic                            busy,
   input  logic                            done,
   input  logic                            err,
   input  ce_pkg::beat_cnt_t               beats_done,
   output logic [ADDR_W-1:0]               src_addr,
   output logic [ADDR_W-1:0]               dst_addr,
   output ce_pkg::beat_cnt_t               size,
   output logic                            start
);
   localparam int DW = ce_pkg::CSR_DATA_W;

   logic          done_sticky;
   logic          err_sticky;
   logic [DW-1:0] status;

   // Start only from a control write with bit 0 set, and never mid-transfer
   assign start = csr_wr && (csr_addr == ce_pkg::REG_CTRL) && csr_wdata[0] && !busy;

   // Live flags are ORed in so a read in the DONE or ERR cycle already sees them
   always_comb begin
      status                    = '0;
      status[ce_pkg::STAT_BUSY] = busy;
      status[ce_pkg::STAT_DONE] = done_sticky | done;
      status[ce_pkg::STAT_ERR]  = err_sticky | err;
   end

   // --------------------
   // Programmed registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         src_addr    <= '0;
         dst_addr    <= '0;
         size        <= '0;
         done_sticky <= 1'b0;
         err_sticky  <= 1'b0;
      end else begin
         if (csr_wr && (csr_addr == ce_pkg::REG_SRC_ADDR))
            src_addr <= csr_wdata[ADDR_W-1:0];
         if (csr_wr && (csr_addr == ce_pkg::REG_DST_ADDR))
            dst_addr <= csr_wdata[ADDR_W-1:0];
         if (csr_wr && (csr_addr == ce_pkg::REG_SIZE))
            size <= ce_pkg::beat_cnt_t'(csr_wdata);
         // Sticky until the next start
         if (start) begin
            done_sticky <= 1'b0;
            err_sticky  <= 1'b0;
         end else begin
            done_sticky <= done_sticky | done;
            err_sticky  <= err_sticky | err;
         end
      end
   end

   // --------------------
   // Read-back, one cycle after csr_rd
   always_ff @(posedge clk) begin
      if (csr_rd) begin
         case (csr_addr)
            ce_pkg::REG_SRC_ADDR:   csr_rdata <= DW'(src_addr);
            ce_pkg::REG_DST_ADDR:   csr_rdata <= DW'(dst_addr);
            ce_pkg::REG_SIZE:       csr_rdata <= DW'(size);
            ce_pkg::REG_STATUS:     csr_rdata <= status;
            ce_pkg::REG_BEATS_DONE: csr_rdata <= DW'(beats_done);
            default:                csr_rdata <= '0;
         endcase
      end
   end

endmodule

/* ce_ctrl_fsm.sv */
`timescale 1ns/1ns
// A request already on the bus is held until accepted even if a faulted completion arrives meanwhile
module ce_ctrl_fsm #(
   parameter int DATA_W = 64,
   parameter int ADDR_W = 32
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  logic [ADDR_W-1:0] src_addr,
   input  ce_pkg::beat_cnt_t size,
   input  logic              can_issue,
   input  ce_pkg::beat_cnt_t next_beats,
   input  logic              all_written,
   input  logic              none_outstanding,
   input  logic              cpl_fault,
   output logic              rd_req_valid,
   output logic [ADDR_W-1:0] rd_req_addr,
   output ce_pkg::beat_cnt_t rd_req_beats,
   input  logic              rd_req_ready,
   output logic              req_fire,
   output logic              busy,
   output logic              done,
   output logic              err,
   output logic              done_irq
);
   localparam int BEAT_BYTES = DATA_W / 8;

   ce_pkg::ce_state_e state;
   ce_pkg::ce_state_e state_nxt;
   logic              fault_seen;
   logic              req_wait;
   logic              stop;
   logic              drain_end;

   // A fault stops new requests from the very cycle it arrives
   assign stop = fault_seen | cpl_fault;

   assign rd_req_valid = (state == ce_pkg::REQ) && can_issue && (req_wait || !stop);
   assign req_fire     = rd_req_valid && rd_req_ready;
   assign rd_req_beats = next_beats;

   assign busy = (state == ce_pkg::REQ) || (state == ce_pkg::DRAIN);
   assign done = (state == ce_pkg::DONE);
   assign err  = (state == ce_pkg::ERR);

   // Error path waits for every reservation to clear
   assign drain_end = stop ? none_outstanding : all_written;
   assign done_irq  = (state == ce_pkg::DRAIN) && drain_end;

   // --------------------
   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         ce_pkg::IDLE, ce_pkg::DONE, ce_pkg::ERR: begin
            if (start)
               state_nxt = (size == '0) ? ce_pkg::DRAIN : ce_pkg::REQ;
            else
               state_nxt = ce_pkg::IDLE;
         end
         ce_pkg::REQ: begin
            if ((stop || next_beats == '0) && !(rd_req_valid && !rd_req_ready))
               state_nxt = ce_pkg::DRAIN;
         end
         ce_pkg::DRAIN: begin
            if (drain_end)
               state_nxt = stop ? ce_pkg::ERR : ce_pkg::DONE;
         end
         default: state_nxt = ce_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= ce_pkg::IDLE;
         fault_seen <= 1'b0;
         req_wait   <= 1'b0;
      end else begin
         state      <= state_nxt;
         fault_seen <= start ? 1'b0 : (fault_seen | cpl_fault);
         req_wait   <= rd_req_valid && !rd_req_ready;
      end
   end

   // Running source address, one request size in bytes per accepted request
   always_ff @(posedge clk) begin
      if (start)
         rd_req_addr <= src_addr;
      else if (req_fire)
         rd_req_addr <= rd_req_addr + ADDR_W'(rd_req_beats) * ADDR_W'(BEAT_BYTES);
   end

endmodule

/* ce_xfer_counter.sv */
`timescale 1ns/1ns
// Expects MAX_REQ_BEATS no larger than BUF_DEPTH and BUF_DEPTH well below the 16-bit beat range
module ce_xfer_counter #(
   parameter int BUF_DEPTH     = 16,
   parameter int MAX_REQ_BEATS = 4
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           start,
   input  ce_pkg::beat_cnt_t              size,
   input  logic                           req_fire,
   input  ce_pkg::beat_cnt_t              rd_req_beats,
   input  logic [$clog2(BUF_DEPTH+1)-1:0] buf_free,
   input  logic                           cpl_fault,
   input  logic                           beat_pop,
   output ce_pkg::beat_cnt_t              next_beats,
   output logic                           can_issue,
   output logic                           all_written,
   output logic                           none_outstanding,
   output ce_pkg::beat_cnt_t              beats_done
);
   localparam int                CNT_W = $clog2(BUF_DEPTH + 1);
   localparam ce_pkg::beat_cnt_t MAX_B = ce_pkg::beat_cnt_t'(MAX_REQ_BEATS);

   ce_pkg::beat_cnt_t left;
   ce_pkg::beat_cnt_t total;
   logic [CNT_W-1:0]  reserved;
   logic [CNT_W-1:0]  res_nxt;
   logic [CNT_W-1:0]  in_flight;

   assign next_beats = (left > MAX_B) ? MAX_B : left;

   // Reserved covers beats in flight plus beats parked in the buffer
   assign in_flight = reserved - (CNT_W'(BUF_DEPTH) - buf_free);
   assign can_issue = (next_beats != '0) &&
                      (ce_pkg::beat_cnt_t'(buf_free) >=
                       ce_pkg::beat_cnt_t'(in_flight) + next_beats);

   assign all_written      = (beats_done == total);
   assign none_outstanding = (reserved == '0);

   always_comb begin
      res_nxt = reserved;
      if (req_fire)
         res_nxt = res_nxt + CNT_W'(rd_req_beats);
      if (beat_pop)
         res_nxt = res_nxt - CNT_W'(1);
      if (cpl_fault)
         res_nxt = res_nxt - CNT_W'(1);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         left       <= '0;
         total      <= '0;
         reserved   <= '0;
         beats_done <= '0;
      end else begin
         reserved <= res_nxt;
         if (start) begin
            left       <= size;
            total      <= size;
            beats_done <= '0;
         end else begin
            if (req_fire)
               left <= left - rd_req_beats;
            if (beat_pop)
               beats_done <= beats_done + 1'b1;
         end
      end
   end

endmodule

/* ce_cpl_buffer.sv */
`timescale 1ns/1ns
// No back-pressure toward the host, so every pushed beat must have space reserved beforehand
module ce_cpl_buffer #(
   parameter int DATA_W    = 64,
   parameter int BUF_DEPTH = 16
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           cpl_valid,
   input  logic [DATA_W-1:0]              cpl_data,
   input  logic                           cpl_err,
   input  logic                           pop,
   output logic [DATA_W-1:0]              head_data,
   output logic                           not_empty,
   output logic [$clog2(BUF_DEPTH+1)-1:0] buf_free,
   output logic                           cpl_fault
);
   localparam int PTR_W = $clog2(BUF_DEPTH);
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   logic [DATA_W-1:0] mem [BUF_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              push;

   // Errored beats never enter the FIFO
   assign push      = cpl_valid && !cpl_err;
   assign cpl_fault = cpl_valid && cpl_err;

   assign head_data = mem[rd_ptr];
   assign not_empty = (count != '0);
   assign buf_free  = CNT_W'(BUF_DEPTH) - count;

   // --------------------
   // Storage
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= cpl_data;
   end

   // Pointers wrap explicitly so the depth need not be a power of two
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* ce_hps_writer.sv */
`timescale 1ns/1ns
// HPS must never return more credits than it was given, the count saturates at WR_CREDITS
module ce_hps_writer #(
   parameter int DATA_W     = 64,
   parameter int ADDR_W     = 32,
   parameter int WR_CREDITS = 2
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  logic [ADDR_W-1:0] dst_addr,
   input  logic              not_empty,
   input  logic [DATA_W-1:0] head_data,
   output logic              pop,
   output logic              wr_valid,
   output logic [ADDR_W-1:0] wr_addr,
   output logic [DATA_W-1:0] wr_data,
   input  logic              wr_credit
);
   localparam int CRD_W      = $clog2(WR_CREDITS + 1);
   localparam int BEAT_BYTES = DATA_W / 8;

   logic [CRD_W-1:0] credits;
   logic [CRD_W-1:0] crd_nxt;

   // One beat out per held credit
   assign pop      = not_empty && (credits != '0);
   assign wr_valid = pop;
   assign wr_data  = head_data;

   always_comb begin
      crd_nxt = credits;
      if (pop)
         crd_nxt = crd_nxt - CRD_W'(1);
      if (wr_credit && crd_nxt != CRD_W'(WR_CREDITS))
         crd_nxt = crd_nxt + CRD_W'(1);
   end

   // --------------------
   // Credit count
   always_ff @(posedge clk) begin
      if (!rst_n)
         credits <= CRD_W'(WR_CREDITS);
      else
         credits <= crd_nxt;
   end

   // Destination address steps one beat per write
   always_ff @(posedge clk) begin
      if (start)
         wr_addr <= dst_addr;
      else if (pop)
         wr_addr <= wr_addr + ADDR_W'(BEAT_BYTES);
   end

endmodule

/* ce_top.sv */
`timescale 1ns/1ns
// Host to HPS copy engine, host must send only requested beats and in request order
module ce_top #(
   parameter int DATA_W        = 64,
   parameter int ADDR_W        = 32,
   parameter int BUF_DEPTH     = 16,
   parameter int MAX_REQ_BEATS = 4,
   parameter int WR_CREDITS    = 2
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // Register port
   input  logic                          csr_wr,
   input  logic                          csr_rd,
   input  logic [ce_pkg::CSR_ADDR_W-1:0] csr_addr,
   input  logic [ce_pkg::CSR_DATA_W-1:0] csr_wdata,
   output logic [ce_pkg::CSR_DATA_W-1:0] csr_rdata,
   // Host read request
   output logic                          rd_req_valid,
   output logic [ADDR_W-1:0]             rd_req_addr,
   output ce_pkg::beat_cnt_t             rd_req_beats,
   input  logic                          rd_req_ready,
   // Host completions
   input  logic                          cpl_valid,
   input  logic [DATA_W-1:0]             cpl_data,
   input  logic                          cpl_err,
   // HPS write
   output logic                          wr_valid,
   output logic [ADDR_W-1:0]             wr_addr,
   output logic [DATA_W-1:0]             wr_data,
   input  logic                          wr_credit,
   output logic                          done_irq
);
   localparam int FREE_W = $clog2(BUF_DEPTH + 1);

   logic              start;
   logic [ADDR_W-1:0] src_addr;
   logic [ADDR_W-1:0] dst_addr;
   ce_pkg::beat_cnt_t size;
   logic              busy;
   logic              done;
   logic              err;
   ce_pkg::beat_cnt_t beats_done;
   ce_pkg::beat_cnt_t next_beats;
   logic              can_issue;
   logic              all_written;
   logic              none_outstanding;
   logic              req_fire;
   logic              cpl_fault;
   logic [FREE_W-1:0] buf_free;
   logic              pop;
   logic [DATA_W-1:0] head_data;
   logic              not_empty;

   ce_csr #(.ADDR_W(ADDR_W)) ce_csr_inst (
      .clk        (clk),        .rst_n      (rst_n),
      .csr_wr     (csr_wr),     .csr_rd     (csr_rd),
      .csr_addr   (csr_addr),   .csr_wdata  (csr_wdata),
      .csr_rdata  (csr_rdata),  .busy       (busy),
      .done       (done),       .err        (err),
      .beats_done (beats_done), .src_addr   (src_addr),
      .dst_addr   (dst_addr),   .size       (size),
      .start      (start)
   );

   ce_ctrl_fsm #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ce_ctrl_fsm_inst (
      .clk          (clk),          .rst_n            (rst_n),
      .start        (start),        .src_addr         (src_addr),
      .size         (size),         .can_issue        (can_issue),
      .next_beats   (next_beats),   .all_written      (all_written),
      .cpl_fault    (cpl_fault),    .none_outstanding (none_outstanding),
      .rd_req_valid (rd_req_valid), .rd_req_addr      (rd_req_addr),
      .rd_req_beats (rd_req_beats), .rd_req_ready     (rd_req_ready),
      .req_fire     (req_fire),     .busy             (busy),
      .done         (done),         .err              (err),
      .done_irq     (done_irq)
   );

   ce_xfer_counter #(.BUF_DEPTH(BUF_DEPTH), .MAX_REQ_BEATS(MAX_REQ_BEATS)) ce_xfer_counter_inst (
      .clk         (clk),          .rst_n            (rst_n),
      .start       (start),        .size             (size),
      .req_fire    (req_fire),     .rd_req_beats     (rd_req_beats),
      .buf_free    (buf_free),     .cpl_fault        (cpl_fault),
      .beat_pop    (pop),          .next_beats       (next_beats),
      .can_issue   (can_issue),    .none_outstanding (none_outstanding),
      .all_written (all_written),  .beats_done       (beats_done)
   );

   ce_cpl_buffer #(.DATA_W(DATA_W), .BUF_DEPTH(BUF_DEPTH)) ce_cpl_buffer_inst (
      .clk       (clk),       .rst_n     (rst_n),
      .cpl_valid (cpl_valid), .cpl_data  (cpl_data),
      .cpl_err   (cpl_err),   .pop       (pop),
      .head_data (head_data), .not_empty (not_empty),
      .buf_free  (buf_free),  .cpl_fault (cpl_fault)
   );

   ce_hps_writer #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .WR_CREDITS(WR_CREDITS)) ce_hps_writer_inst (
      .clk       (clk),       .rst_n     (rst_n),
      .start     (start),     .dst_addr  (dst_addr),
      .not_empty (not_empty), .head_data (head_data),
      .pop       (pop),       .wr_valid  (wr_valid),
      .wr_addr   (wr_addr),   .wr_data   (wr_data),
      .wr_credit (wr_credit)
   );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ns
// Free-running 40 ns clock and a reset held low for the first 4 rising edges
module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* ce_properties.sv */
`timescale 1ns/1ns
// Assumes one transfer at a time and an HPS side that returns exactly one credit per write
module ce_properties #(
   parameter int ADDR_W        = 32,
   parameter int BUF_DEPTH     = 16,
   parameter int MAX_REQ_BEATS = 4,
   parameter int WR_CREDITS    = 2
) (
   input logic              clk,
   input logic              rst_n,
   input logic              start,
   input ce_pkg::beat_cnt_t size,
   input logic              rd_req_valid,
   input logic [ADDR_W-1:0] rd_req_addr,
   input ce_pkg::beat_cnt_t rd_req_beats,
   input logic              rd_req_ready,
   input logic              req_fire,
   input logic              cpl_valid,
   input logic              cpl_err,
   input logic              wr_valid,
   input logic              wr_credit,
   input logic              done_irq,
   input ce_pkg::ce_state_e state
);
   int   credits;
   int   inflight;
   int   req_sum;
   logic fault_seen;
   int   fail_cnt = 0;

   // --------------------
   // Shadow counters
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits    <= WR_CREDITS;
         inflight   <= 0;
         req_sum    <= 0;
         fault_seen <= 1'b0;
      end else begin
         credits  <= credits - int'(wr_valid) + int'(wr_credit);
         // Beats requested but not yet written or dropped
         inflight <= inflight + (req_fire ? int'(rd_req_beats) : 0)
                     - int'(wr_valid) - int'(cpl_valid && cpl_err);
         if (start) begin
            req_sum    <= 0;
            fault_seen <= 1'b0;
         end else begin
            if (req_fire)
               req_sum <= req_sum + int'(rd_req_beats);
            if (cpl_valid && cpl_err)
               fault_seen <= 1'b1;
         end
      end
   end

   // --------------------
   // Read request rules
   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rd_req_valid && !rd_req_ready |=>
         rd_req_valid && $stable(rd_req_addr) && $stable(rd_req_beats))
      else begin
         fail_cnt++;
         $error("read request dropped or changed before it was accepted");
      end

   a_req_beats: assert property (@(posedge clk) disable iff (!rst_n)
      rd_req_valid |-> rd_req_beats >= 1 && int'(rd_req_beats) <= MAX_REQ_BEATS)
      else begin
         fail_cnt++;
         $error("read request beat count out of range");
      end

   a_req_bound: assert property (@(posedge clk) disable iff (!rst_n)
      req_fire |-> req_sum + int'(rd_req_beats) <= int'(size))
      else begin
         fail_cnt++;
         $error("requested beats exceed the programmed size");
      end

   a_req_total: assert property (@(posedge clk) disable iff (!rst_n)
      done_irq && !fault_seen |-> req_sum == int'(size))
      else begin
         fail_cnt++;
         $error("requested beats do not add up to the programmed size");
      end

   a_req_space: assert property (@(posedge clk) disable iff (!rst_n)
      req_fire |-> inflight + int'(rd_req_beats) <= BUF_DEPTH)
      else begin
         fail_cnt++;
         $error("request issued without room in the completion buffer");
      end

   a_start_req: assert property (@(posedge clk) disable iff (!rst_n)
      (start && size != '0) |-> ##[1:2] rd_req_valid)
      else begin
         fail_cnt++;
         $error("first read request came too late after the start write");
      end

   a_no_req_after_fault: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(rd_req_valid) |-> !fault_seen)
      else begin
         fail_cnt++;
         $error("new read request after a faulted completion");
      end

   // --------------------
   // HPS write and end of transfer
   a_credit: assert property (@(posedge clk) disable iff (!rst_n)
      wr_valid |-> credits > 0)
      else begin
         fail_cnt++;
         $error("HPS write issued without a credit");
      end

   a_irq_end: assert property (@(posedge clk) disable iff (!rst_n)
      done_irq |=> (fault_seen ? (state == ce_pkg::ERR) : (state == ce_pkg::DONE)))
      else begin
         fail_cnt++;
         $error("transfer ended in the wrong state for its completions");
      end

endmodule

/* tb_ce_top.sv */
`timescale 1ns/1ns
// Runs one clean transfer and one with an injected completion error on fixed DUT parameters
module tb_ce_top;
   localparam int DATA_W        = 64;
   localparam int ADDR_W        = 32;
   localparam int BUF_DEPTH     = 16;
   localparam int MAX_REQ_BEATS = 4;
   localparam int WR_CREDITS    = 2;
   localparam int BEAT_BYTES    = DATA_W / 8;
   localparam int TIMEOUT       = 2000;

   logic                          clk;
   logic                          rst_n;
   logic                          csr_wr;
   logic                          csr_rd;
   logic [ce_pkg::CSR_ADDR_W-1:0] csr_addr;
   logic [ce_pkg::CSR_DATA_W-1:0] csr_wdata;
   logic [ce_pkg::CSR_DATA_W-1:0] csr_rdata;
   logic                          rd_req_valid;
   logic [ADDR_W-1:0]             rd_req_addr;
   ce_pkg::beat_cnt_t             rd_req_beats;
   logic                          rd_req_ready;
   logic                          cpl_valid;
   logic [DATA_W-1:0]             cpl_data;
   logic                          cpl_err;
   logic                          wr_valid;
   logic [ADDR_W-1:0]             wr_addr;
   logic [DATA_W-1:0]             wr_data;
   logic                          wr_credit;
   logic                          done_irq;

   // Host and HPS model state
   logic [ADDR_W-1:0]             req_addr_q[$];
   ce_pkg::beat_cnt_t             req_beats_q[$];
   logic [ADDR_W-1:0]             cpl_addr;
   int unsigned                   cpl_left;
   int unsigned                   cpl_delay;
   int unsigned                   crd_pending;
   int unsigned                   crd_delay;

   // Expected transfer and results
   logic [ADDR_W-1:0]             cur_src;
   logic [ADDR_W-1:0]             cur_dst;
   logic [ADDR_W-1:0]             err_addr;
   logic [ADDR_W-1:0]             last_wr_addr;
   logic [ADDR_W-1:0]             exp_off;
   logic                          err_on;
   logic                          have_last;
   logic [ce_pkg::CSR_DATA_W-1:0] rdata;
   int                            wr_count;
   int                            done_cnt;
   int                            mismatches;
   int                            timeouts;
   int                            prop_fails;

   tb_clk_gen i_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   ce_top #(
      .DATA_W        (DATA_W),
      .ADDR_W        (ADDR_W),
      .BUF_DEPTH     (BUF_DEPTH),
      .MAX_REQ_BEATS (MAX_REQ_BEATS),
      .WR_CREDITS    (WR_CREDITS)
   ) i_dut (
      .clk          (clk),          .rst_n        (rst_n),
      .csr_wr       (csr_wr),       .csr_rd       (csr_rd),
      .csr_addr     (csr_addr),     .csr_wdata    (csr_wdata),
      .csr_rdata    (csr_rdata),    .rd_req_valid (rd_req_valid),
      .rd_req_addr  (rd_req_addr),  .rd_req_beats (rd_req_beats),
      .rd_req_ready (rd_req_ready), .cpl_valid    (cpl_valid),
      .cpl_data     (cpl_data),     .cpl_err      (cpl_err),
      .wr_valid     (wr_valid),     .wr_addr      (wr_addr),
      .wr_data      (wr_data),      .wr_credit    (wr_credit),
      .done_irq     (done_irq)
   );

   bind ce_top ce_properties #(
      .ADDR_W        (ADDR_W),
      .BUF_DEPTH     (BUF_DEPTH),
      .MAX_REQ_BEATS (MAX_REQ_BEATS),
      .WR_CREDITS    (WR_CREDITS)
   ) i_props (
      .clk          (clk),          .rst_n        (rst_n),
      .start        (start),        .size         (size),
      .rd_req_valid (rd_req_valid), .rd_req_addr  (rd_req_addr),
      .rd_req_beats (rd_req_beats), .rd_req_ready (rd_req_ready),
      .req_fire     (req_fire),     .cpl_valid    (cpl_valid),
      .cpl_err      (cpl_err),      .wr_valid     (wr_valid),
      .wr_credit    (wr_credit),    .done_irq     (done_irq),
      .state        (ce_ctrl_fsm_inst.state)
   );

   task automatic expect_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
      assert (got == exp) else begin
         mismatches++;
         $display("mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic write_reg(input logic [ce_pkg::CSR_ADDR_W-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      csr_wr    <= 1'b1;
      csr_addr  <= addr;
      csr_wdata <= data;
      @(posedge clk);
      csr_wr <= 1'b0;
   endtask

   // Read data is registered, so it is taken one edge after the request is seen
   task automatic read_reg(input logic [ce_pkg::CSR_ADDR_W-1:0] addr,
                           output logic [ce_pkg::CSR_DATA_W-1:0] data);
      @(posedge clk);
      csr_rd   <= 1'b1;
      csr_addr <= addr;
      @(posedge clk);
      csr_rd <= 1'b0;
      @(posedge clk);
      data = csr_rdata;
   endtask

   task automatic await_irq(input int target);
      int n;
      n = 0;
      while (done_cnt < target && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (done_cnt < target) begin
         timeouts++;
         $display("timeout waiting for the done interrupt of transfer %0d", target);
      end
   endtask

   // A negative bad_beat means no completion is flagged
   task automatic run_transfer(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                               input int beats, input int bad_beat, input int irq_no);
      cur_src   = src;
      cur_dst   = dst;
      wr_count  = 0;
      have_last = 1'b0;
      err_on    = (bad_beat >= 0);
      err_addr  = src + ADDR_W'(bad_beat * BEAT_BYTES);
      write_reg(ce_pkg::REG_SRC_ADDR, src);
      write_reg(ce_pkg::REG_DST_ADDR, dst);
      write_reg(ce_pkg::REG_SIZE, beats);
      read_reg(ce_pkg::REG_SRC_ADDR, rdata);
      expect_equal("csr_rdata src_addr", rdata, src);
      read_reg(ce_pkg::REG_DST_ADDR, rdata);
      expect_equal("csr_rdata dst_addr", rdata, dst);
      read_reg(ce_pkg::REG_SIZE, rdata);
      expect_equal("csr_rdata size", rdata, beats);
      write_reg(ce_pkg::REG_CTRL, 32'h1);
      await_irq(irq_no);
   endtask

   // --------------------
   // Host model with random ready and delayed in-order completions
   always @(posedge clk) begin
      if (rd_req_valid && rd_req_ready) begin
         req_addr_q.push_back(rd_req_addr);
         req_beats_q.push_back(rd_req_beats);
      end
      rd_req_ready <= ($urandom % 3) != 0;
      cpl_valid    <= 1'b0;
      cpl_err      <= 1'b0;
      if (cpl_delay != 0) begin
         cpl_delay--;
      end else if (cpl_left != 0) begin
         cpl_valid <= 1'b1;
         cpl_data  <= DATA_W'(cpl_addr);
         cpl_err   <= err_on && (cpl_addr == err_addr);
         cpl_addr  = cpl_addr + ADDR_W'(BEAT_BYTES);
         cpl_left--;
      end else if (req_addr_q.size() != 0) begin
         cpl_addr  = req_addr_q.pop_front();
         cpl_left  = req_beats_q.pop_front();
         cpl_delay = $urandom % 4;
      end
   end

   // --------------------
   // HPS model with write checks and sparse credit return
   always @(posedge clk) begin
      wr_credit <= 1'b0;
      if (done_irq)
         done_cnt++;
      if (wr_valid) begin
         wr_count++;
         crd_pending++;
         // The dropped beat moves every later beat down one destination slot
         exp_off = wr_addr - cur_dst;
         if (err_on && cur_src + exp_off >= err_addr)
            exp_off = exp_off + ADDR_W'(BEAT_BYTES);
         expect_equal("wr_data", wr_data, DATA_W'(cur_src + exp_off));
         assert (!have_last || wr_addr > last_wr_addr) else begin
            mismatches++;
            $display("mismatch wr_addr: got %h, previous %h", wr_addr, last_wr_addr);
         end
         assert (!(err_on && wr_data == DATA_W'(err_addr))) else begin
            mismatches++;
            $display("the beat with the completion error was written at %h", wr_addr);
         end
         have_last    = 1'b1;
         last_wr_addr = wr_addr;
      end
      if (crd_delay != 0) begin
         crd_delay--;
      end else if (crd_pending != 0) begin
         wr_credit <= 1'b1;
         crd_pending--;
         crd_delay = $urandom % 6;
      end
   end

   // --------------------
   // Main sequence
   initial begin
      int n;
      void'($urandom(5752));
      csr_wr       = 1'b0;
      csr_rd       = 1'b0;
      csr_addr     = '0;
      csr_wdata    = '0;
      rd_req_ready = 1'b0;
      cpl_valid    = 1'b0;
      cpl_data     = '0;
      cpl_err      = 1'b0;
      wr_credit    = 1'b0;
      cpl_left     = 0;
      cpl_delay    = 0;
      crd_pending  = 0;
      crd_delay    = 0;
      err_on       = 1'b0;
      have_last    = 1'b0;
      wr_count     = 0;
      done_cnt     = 0;
      mismatches   = 0;
      timeouts     = 0;

      n = 0;
      while (!rst_n && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (!rst_n) begin
         timeouts++;
         $display("timeout waiting for reset release");
      end
      read_reg(ce_pkg::REG_STATUS, rdata);
      expect_equal("csr_rdata status", rdata, 0);

      // 10 beats, so the last request is shorter than MAX_REQ_BEATS
      run_transfer(32'h0000_1000, 32'h0008_0000, 10, -1, 1);
      read_reg(ce_pkg::REG_STATUS, rdata);
      expect_equal("csr_rdata status", rdata, 1 << ce_pkg::STAT_DONE);
      read_reg(ce_pkg::REG_BEATS_DONE, rdata);
      expect_equal("csr_rdata beats_done", rdata, 10);
      expect_equal("wr_valid count", wr_count, 10);
      expect_equal("done_irq count", done_cnt, 1);

      // Third beat comes back flagged
      run_transfer(32'h0000_4000, 32'h000A_0000, 13, 2, 2);
      read_reg(ce_pkg::REG_STATUS, rdata);
      expect_equal("csr_rdata status", rdata, 1 << ce_pkg::STAT_ERR);
      expect_equal("done_irq count", done_cnt, 2);

      prop_fails = i_dut.i_props.fail_cnt;
      $display("errors: %0d mismatches, %0d timeouts, %0d property failures",
               mismatches, timeouts, prop_fails);
      if (mismatches + timeouts + prop_fails == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* files.f */
ce_pkg.sv
ce_csr.sv
ce_ctrl_fsm.sv
ce_xfer_counter.sv
ce_cpl_buffer.sv
ce_hps_writer.sv
ce_top.sv
tb_clk_gen.sv
ce_properties.sv
tb_ce_top.sv

/* Bender.yml */
package:
  name: ce_copy_engine

sources:
  - ce_pkg.sv
  - ce_csr.sv
  - ce_ctrl_fsm.sv
  - ce_xfer_counter.sv
  - ce_cpl_buffer.sv
  - ce_hps_writer.sv
  - ce_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - ce_properties.sv
      - tb_ce_top.sv
